// ==== verif/feed_testdata.hex ====
# M block offset byte : one byte of the SD image (hex)
# V fail : expected verdict of the next test, in order
M 00100000 000 aa
M 00100000 001 bb
M 00100000 002 cc
M 00100000 003 dd
M 00100000 004 11
M 00100000 005 22
M 00100000 006 33
M 00100000 00c 10
M 00100000 00e 10
M 00100000 010 08
M 00100000 018 44
M 00100000 019 33
M 00100000 01a 22
M 00100000 01b 11
M 00100001 000 01
M 00100001 001 02
M 00100001 002 03
M 00100001 003 04
M 00100001 004 10
M 00100001 005 20
M 00100001 006 30
M 00100001 007 40
M 00100010 000 aa
M 00100010 001 bb
M 00100010 002 cc
M 00100010 003 dd
M 00100010 004 5a
M 00100010 00b a5
M 00100010 00c 20
M 00100010 00e 10
M 00100010 010 04
M 00100010 018 ff
M 00100011 000 de
M 00100011 001 ad
M 00100011 002 be
M 00100011 003 ef
M 00100020 000 aa
M 00100020 001 bb
M 00100020 002 cc
M 00100020 003 de
V 0
V 1

// ==== files.f ====
common/sd_host_pkg.sv
common/test_format_pkg.sv
sequencer/sd_test_sequencer.sv
src/control_block_parser.sv
src/feed_word_assembler.sv
src/result_checker.sv
src/feed_test_ctrl.sv
verif/feed_test_models.sv
verif/feed_test_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= feed_test_ctrl_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  := Test completed successfully

SRCS := $(shell cat files.f)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): files.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f files.f --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/feed_test_ctrl_tb.sv ====
`timescale 1ns/1ps

/*
 * Feed test controller testbench
 * SD image and expected verdicts come from the testdata file
 */
module feed_test_ctrl_tb;
  import test_format_pkg::*;

  // three control blocks and the feed bytes, at most 8 cycles a byte, plus margin
  localparam int MAX_CYCLES = 4 * 512 * 8 + 4000;

  logic clk = 1'b0;
  logic rst;
  logic start_i;
  sd_host_pkg::sd_cmd_t sd_cmd;
  sd_host_pkg::sd_rsp_t sd_rsp;
  logic [31:0] sd_addr;
  uut_ctrl_t   uut_ctrl;
  uut_status_t uut_status;
  logic [63:0] uut_input;
  logic [31:0] feed_word, uut_result, error_count;
  logic        verdict_valid, verdict_fail, halted;

  logic [7:0]  image [logic [40:0]];
  logic        v_fail [$];
  int          cycles = 0;
  int          verdicts = 0;
  int          cb_opens = 0;
  int          pulses = 0;
  int          stops = 0;
  int          fail_total = 0;
  logic        prev_read_block = 1'b0;
  logic [31:0] expect_blk = sd_host_pkg::START_BLOCK;
  logic [31:0] cur_blk, cur_next, cur_expected, cur_sig, word_xor;
  logic [63:0] cur_input, cur_total;

  always #5 clk = ~clk;

  feed_test_ctrl feed_test_ctrl_i (
    .clk (clk), .rst (rst), .start_i (start_i),
    .sd_cmd_o (sd_cmd), .sd_addr_o (sd_addr), .sd_rsp_i (sd_rsp),
    .uut_ctrl_o (uut_ctrl), .uut_status_i (uut_status),
    .uut_input_o (uut_input), .feed_word_o (feed_word), .uut_result_i (uut_result),
    .verdict_valid_o (verdict_valid), .verdict_fail_o (verdict_fail),
    .error_count_o (error_count), .halted_o (halted)
  );

  sd_card_model sd_card_i (.clk (clk), .cmd_i (sd_cmd), .addr_i (sd_addr), .rsp_o (sd_rsp));
  uut_model uut_i (
    .clk (clk), .ctrl_i (uut_ctrl), .word_i (feed_word),
    .status_o (uut_status), .result_o (uut_result)
  );

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic logic [7:0] image_at(input logic [31:0] blk, input logic [31:0] off);
    logic [40:0] key;
    key = {blk + (off >> 9), off[8:0]};
    if (image.exists(key)) return image[key];
    return 8'h00;
  endfunction

  // card fields are stored lsb first
  function automatic logic [63:0] field_le(input logic [31:0] blk, input int off, input int n);
    logic [63:0] v;
    v = '0;
    for (int i = n - 1; i >= 0; i--) v = {v[55:0], image_at(blk, off + i)};
    return v;
  endfunction

  function automatic logic [31:0] feed_word_at(input logic [31:0] blk, input int k);
    logic [31:0] w;
    w = '0;
    for (int j = 0; j < FEED_BYTES; j++) w = {w[23:0], image_at(blk + 1, FEED_BYTES * k + j)};
    return w;
  endfunction

  task automatic read_testdata();
    int fd, n;
    string line;
    logic [31:0] a, b, c;
    fd = $fopen("verif/feed_testdata.hex", "r");
    if (fd == 0) abort_run("cannot open verif/feed_testdata.hex");
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line[0] == "M") begin
        n = $sscanf(line, "M %h %h %h", a, b, c);
        image[{a, b[8:0]}] = c[7:0];
        sd_card_i.load_byte(a, b[8:0], c[7:0]);
      end else if (n > 0 && line[0] == "V") begin
        n = $sscanf(line, "V %h", a);
        v_fail.push_back(a[0]);
      end
    end
    $fclose(fd);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) abort_run("run did not finish within the cycle limit");
  end

  ////////////////////////////////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    prev_read_block <= sd_cmd.read_block;
    if (sd_cmd.read_block && !prev_read_block) begin
      check_value("sd_addr_o", sd_addr, expect_blk);
      // UUT held in reset until the feed phase
      check_value("uut_ctrl_o.rst", uut_ctrl.rst, 1'b1);
      cur_blk      = sd_addr;
      cur_sig      = field_le(sd_addr, 0, 4);
      cur_sig      = {cur_sig[7:0], cur_sig[15:8], cur_sig[23:16], cur_sig[31:24]};
      cur_input    = field_le(sd_addr, INPUT_OFFSET, INPUT_BYTES);
      cur_next     = field_le(sd_addr, NEXT_OFFSET, NEXT_BYTES);
      cur_total    = field_le(sd_addr, TOTAL_OFFSET, TOTAL_BYTES_LEN);
      cur_expected = field_le(sd_addr, EXPECT_OFFSET, EXPECT_BYTES);
      pulses       = 0;
      stops        = 0;
      word_xor     = '0;
      cb_opens++;
    end
    if (uut_ctrl.feed) begin
      check_value("halted_o at feed pulse", halted, 1'b0);
      if (pulses == 0) check_value("uut_input_o", uut_input, cur_input);
      check_value("feed_word_o", feed_word, feed_word_at(cur_blk, pulses));
      word_xor = word_xor ^ feed_word_at(cur_blk, pulses);
      pulses++;
    end
    if (uut_ctrl.stop_feed) begin
      check_value("feed pulses at uut_ctrl_o.stop_feed", pulses, cur_total / FEED_BYTES);
      stops++;
    end
    if (verdict_valid) begin
      if (verdicts >= v_fail.size()) abort_run("more verdicts than testdata records");
      check_value("testdata verdict", v_fail[verdicts], cur_expected != word_xor);
      check_value("verdict_fail_o", verdict_fail, v_fail[verdicts]);
      check_value("feed pulse count", pulses, cur_total / FEED_BYTES);
      check_value("uut_ctrl_o.stop_feed cycles", stops, 1);
      fail_total += v_fail[verdicts];
      check_value("error_count_o", error_count, fail_total);
      expect_blk = cur_next;
      verdicts++;
    end
  end

  initial begin
    rst     = 1'b1;
    start_i = 1'b0;
    read_testdata();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    check_value("sd_cmd_o", sd_cmd, '0);
    check_value("uut_ctrl_o", uut_ctrl, '0);
    check_value("halted_o", halted, 1'b0);
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    while (!halted) @(posedge clk);
    check_value("verdicts before halt", verdicts, v_fail.size());
    check_value("signature of halting block ok", cur_sig == SIGNATURE, 1'b0);
    // no feed may follow the halt
    repeat (100) @(posedge clk);
    check_value("halted_o", halted, 1'b1);
    check_value("control block reads", cb_opens, v_fail.size() + 1);
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== verif/feed_test_models.sv ====
`timescale 1ns/1ps

/*
 * Testbench models
 * byte-wide SD card with a sparse block image, and a UUT that
 * folds each feed word into its result by XOR
 */
module sd_card_model (
  input  logic                 clk,
  input  sd_host_pkg::sd_cmd_t cmd_i,
  input  logic [31:0]          addr_i,
  output sd_host_pkg::sd_rsp_t rsp_o
);
  logic [7:0]  image [logic [40:0]];
  logic [31:0] seed;
  logic [2:0]  busy_left;
  logic        opened;
  logic [31:0] blk;
  logic [8:0]  ptr;

  task automatic load_byte(input logic [31:0] b, input logic [8:0] o, input logic [7:0] v);
    image[{b, o}] = v;
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // bytes never written read as zero
  function automatic logic [7:0] stored_byte(input logic [31:0] b, input logic [8:0] o);
    if (image.exists({b, o})) return image[{b, o}];
    return 8'h00;
  endfunction

  initial begin
    rsp_o     = '0;
    seed      = 32'he366;
    busy_left = '0;
    opened    = 1'b0;
    blk       = '0;
    ptr       = '0;
  end

  always @(posedge clk) begin
    if (!cmd_i.read_block && !cmd_i.read_multi) opened <= 1'b0;
    if (rsp_o.busy) begin
      if (busy_left == 3'd1) rsp_o.busy <= 1'b0;
      busy_left <= busy_left - 3'd1;
    end else if (cmd_i.rst || cmd_i.read_byte ||
                 ((cmd_i.read_block || cmd_i.read_multi) && !opened)) begin
      seed       <= lcg_next(seed);
      busy_left  <= {1'b0, seed[17:16]} + 3'd1;
      rsp_o.busy <= 1'b1;
      if (cmd_i.read_byte) begin
        rsp_o.data <= stored_byte(blk, ptr);
        ptr        <= ptr + 9'd1;
        // multi-block reads run on into the next block
        if (ptr == 9'h1ff) blk <= blk + 32'd1;
      end else if (!cmd_i.rst) begin
        opened <= 1'b1;
        blk    <= addr_i;
        ptr    <= '0;
      end
    end
  end

endmodule

module uut_model (
  input  logic                         clk,
  input  test_format_pkg::uut_ctrl_t   ctrl_i,
  input  logic [31:0]                  word_i,
  output test_format_pkg::uut_status_t status_o,
  output logic [31:0]                  result_o
);
  logic [31:0] seed;
  logic [3:0]  busy_left;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    status_o  = '0;
    result_o  = '0;
    seed      = 32'he366;
    busy_left = '0;
  end

  always @(posedge clk) begin
    if (ctrl_i.rst) begin
      status_o  <= '0;
      result_o  <= '0;
      busy_left <= '0;
    end else begin
      if (ctrl_i.feed) begin
        result_o        <= result_o ^ word_i;
        status_o.busy   <= 1'b1;
        seed            <= lcg_next(seed);
        busy_left       <= {1'b0, seed[18:16]} + 4'd1;
      end else if (status_o.busy) begin
        if (busy_left == 4'd1) status_o.busy <= 1'b0;
        busy_left <= busy_left - 4'd1;
      end
      if (ctrl_i.stop_feed) status_o.done <= 1'b1;
    end
  end

endmodule

// ==== src/feed_test_ctrl.sv ====
`timescale 1ns/1ps

/*
 * Feed test controller
 * reads test control blocks from an SD card, feeds the UUT
 * and checks its result against the expected value
 */
module feed_test_ctrl (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          start_i,
  output sd_host_pkg::sd_cmd_t                          sd_cmd_o,
  output logic [31:0]                                   sd_addr_o,
  input  sd_host_pkg::sd_rsp_t                          sd_rsp_i,
  output test_format_pkg::uut_ctrl_t                    uut_ctrl_o,
  input  test_format_pkg::uut_status_t                  uut_status_i,
  output logic [8*test_format_pkg::INPUT_BYTES-1:0]     uut_input_o,
  output logic [8*test_format_pkg::FEED_BYTES-1:0]      feed_word_o,
  input  logic [test_format_pkg::RESULT_W-1:0]          uut_result_i,
  output logic                                          verdict_valid_o,
  output logic                                          verdict_fail_o,
  output logic [31:0]                                   error_count_o,
  output logic                                          halted_o
);
  import test_format_pkg::*;

  control_block_t cb;
  logic           sig_ok;
  logic           word_full;
  logic           ctrl_byte_valid;
  logic           feed_byte_valid;
  logic           block_clear;
  logic           asm_clear;
  logic           result_capture;
  logic           compare;
  logic           session_rst;

  // the feed word empties at every block start and every feed pulse
  assign asm_clear   = block_clear | uut_ctrl_o.feed;
  // error count restarts with each session
  assign session_rst = rst | start_i;
  assign uut_input_o = cb.test_input;

  sd_test_sequencer sd_test_sequencer_i (
    .clk               (clk),
    .rst               (rst),
    .start_i           (start_i),
    .sd_cmd_o          (sd_cmd_o),
    .sd_addr_o         (sd_addr_o),
    .sd_busy_i         (sd_rsp_i.busy),
    .uut_ctrl_o        (uut_ctrl_o),
    .uut_busy_i        (uut_status_i.busy),
    .uut_end_i         (uut_status_i.done),
    .uut_err_i         (uut_status_i.error),
    .cb_i              (cb),
    .sig_ok_i          (sig_ok),
    .word_full_i       (word_full),
    .ctrl_byte_valid_o (ctrl_byte_valid),
    .feed_byte_valid_o (feed_byte_valid),
    .block_clear_o     (block_clear),
    .result_capture_o  (result_capture),
    .compare_o         (compare),
    .halted_o          (halted_o)
  );

  control_block_parser control_block_parser_i (
    .clk          (clk),
    .rst          (rst),
    .clear_i      (block_clear),
    .byte_valid_i (ctrl_byte_valid),
    .byte_i       (sd_rsp_i.data),
    .cb_o         (cb),
    .sig_ok_o     (sig_ok)
  );

  feed_word_assembler feed_word_assembler_i (
    .clk          (clk),
    .rst          (rst),
    .clear_i      (asm_clear),
    .byte_valid_i (feed_byte_valid),
    .byte_i       (sd_rsp_i.data),
    .word_o       (feed_word_o),
    .word_full_o  (word_full)
  );

  result_checker result_checker_i (
    .clk             (clk),
    .rst             (session_rst),
    .capture_i       (result_capture),
    .compare_i       (compare),
    .result_i        (uut_result_i),
    .expected_i      (cb.expected),
    .uut_err_i       (uut_status_i.error),
    .verdict_valid_o (verdict_valid_o),
    .verdict_fail_o  (verdict_fail_o),
    .error_count_o   (error_count_o)
  );

endmodule

// ==== src/result_checker.sv ====
`timescale 1ns/1ps

/*
 * Result checker
 * compares the UUT result with the expected value and counts fails
 */
module result_checker (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                capture_i,
  input  logic                                compare_i,
  input  logic [test_format_pkg::RESULT_W-1:0] result_i,
  input  logic [test_format_pkg::RESULT_W-1:0] expected_i,
  input  logic                                uut_err_i,
  output logic                                verdict_valid_o,
  output logic                                verdict_fail_o,
  output logic [31:0]                         error_count_o
);
  import test_format_pkg::*;

  logic [RESULT_W-1:0] result_q;
  logic                err_q;
  logic                fail;

  always_ff @(posedge clk) begin
    if (capture_i) begin
      result_q <= result_i;
      err_q    <= uut_err_i;
    end
  end

  assign fail = (result_q != expected_i) || err_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      verdict_valid_o <= 1'b0;
      verdict_fail_o  <= 1'b0;
      error_count_o   <= '0;
    end else begin
      verdict_valid_o <= compare_i;
      verdict_fail_o  <= compare_i & fail;
      if (compare_i && fail) begin
        error_count_o <= error_count_o + 32'd1;
      end
    end
  end

endmodule

// ==== src/feed_word_assembler.sv ====
`timescale 1ns/1ps

/*
 * Feed word assembler
 * packs feed bytes big-endian into one UUT feed word
 */
module feed_word_assembler (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     clear_i,
  input  logic                                     byte_valid_i,
  input  logic [7:0]                               byte_i,
  output logic [8*test_format_pkg::FEED_BYTES-1:0] word_o,
  output logic                                     word_full_o
);
  import test_format_pkg::*;

  logic [FEED_CNT_W-1:0] fill;

  assign word_full_o = (fill == FEED_CNT_W'(FEED_BYTES));

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      fill <= '0;
    end else if (byte_valid_i && !word_full_o) begin
      fill <= fill + 1'b1;
    end
  end

  // first byte ends up in the top lane
  always_ff @(posedge clk) begin
    if (byte_valid_i && !word_full_o) begin
      word_o <= {word_o[8*FEED_BYTES-9:0], byte_i};
    end
  end

endmodule

// ==== src/control_block_parser.sv ====
`timescale 1ns/1ps

/*
 * Control block parser
 * picks the control block fields out of the SD byte stream
 * by their byte offset and checks the signature
 */
module control_block_parser (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            clear_i,
  input  logic                            byte_valid_i,
  input  logic [7:0]                      byte_i,
  output test_format_pkg::control_block_t cb_o,
  output logic                            sig_ok_o
);
  import test_format_pkg::*;

  localparam logic [CB_CNT_W-1:0] CB_END = CB_CNT_W'(CB_BYTES);

  logic [CB_CNT_W-1:0] offset;
  control_block_t      cb_q;

  // stops counting past the last field
  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      offset <= '0;
    end else if (byte_valid_i && offset != CB_END) begin
      offset <= offset + 1'b1;
    end
  end

  // signature arrives msb first, the other fields lsb first
  always_ff @(posedge clk) begin
    if (clear_i) begin
      cb_q.signature <= '0;
    end else if (byte_valid_i) begin
      if (offset < CB_CNT_W'(INPUT_OFFSET)) begin
        cb_q.signature <= {cb_q.signature[8*SIG_BYTES-9:0], byte_i};
      end else if (offset < CB_CNT_W'(NEXT_OFFSET)) begin
        cb_q.test_input <= {byte_i, cb_q.test_input[8*INPUT_BYTES-1:8]};
      end else if (offset < CB_CNT_W'(TOTAL_OFFSET)) begin
        cb_q.next_block <= {byte_i, cb_q.next_block[8*NEXT_BYTES-1:8]};
      end else if (offset < CB_CNT_W'(EXPECT_OFFSET)) begin
        cb_q.total_bytes <= {byte_i, cb_q.total_bytes[8*TOTAL_BYTES_LEN-1:8]};
      end else if (offset < CB_END) begin
        cb_q.expected <= {byte_i, cb_q.expected[8*EXPECT_BYTES-1:8]};
      end
    end
  end

  assign cb_o     = cb_q;
  assign sig_ok_o = (cb_q.signature == SIGNATURE);

endmodule

// ==== sequencer/sd_test_sequencer.sv ====
`timescale 1ns/1ps

/*
 * SD test sequencer
 * walks the control blocks on the card, streams feed words to the
 * UUT over a multi-block read and runs the end and compare phase
 */
module sd_test_sequencer (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start_i,
  output sd_host_pkg::sd_cmd_t            sd_cmd_o,
  output logic [31:0]                     sd_addr_o,
  input  logic                            sd_busy_i,
  output test_format_pkg::uut_ctrl_t      uut_ctrl_o,
  input  logic                            uut_busy_i,
  input  logic                            uut_end_i,
  input  logic                            uut_err_i,
  input  test_format_pkg::control_block_t cb_i,
  input  logic                            sig_ok_i,
  input  logic                            word_full_i,
  output logic                            ctrl_byte_valid_o,
  output logic                            feed_byte_valid_o,
  output logic                            block_clear_o,
  output logic                            result_capture_o,
  output logic                            compare_o,
  output logic                            halted_o
);
  import sd_host_pkg::*;
  import test_format_pkg::*;

  localparam logic [BYTE_CNT_W-1:0] LAST_BYTE = BYTE_CNT_W'(BLOCK_BYTES - 1);

  seq_state_e            state;
  logic [31:0]           current_block;
  logic [31:0]           block_addr;
  logic [BYTE_CNT_W-1:0] block_byte_cnt;
  logic [63:0]           fed_bytes;
  logic [31:0]           exec_cnt;
  logic                  exec_over;
  logic                  feed_done;

  assign feed_done = (fed_bytes >= cb_i.total_bytes);
  assign exec_over = uut_end_i | uut_err_i | (exec_cnt == EXEC_TIMEOUT - 32'd1);
  assign sd_addr_o = block_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= ST_IDLE;
      current_block  <= START_BLOCK;
      block_addr     <= START_BLOCK;
      block_byte_cnt <= '0;
      fed_bytes      <= '0;
      exec_cnt       <= '0;
      halted_o       <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: if (start_i) begin
          current_block <= START_BLOCK;
          halted_o      <= 1'b0;
          state         <= ST_SD_RESET;
        end
        ST_SD_RESET:      if (sd_busy_i) state <= ST_SD_RESET_WAIT;
        ST_SD_RESET_WAIT: if (!sd_busy_i) state <= ST_CB_SETUP;
        ST_CB_SETUP: if (!sd_busy_i) begin
          block_addr     <= current_block;
          block_byte_cnt <= '0;
          state          <= ST_CB_REQ;
        end
        ST_CB_REQ:       if (sd_busy_i) state <= ST_CB_OPEN_WAIT;
        ST_CB_OPEN_WAIT: if (!sd_busy_i) state <= ST_CB_BYTE_REQ;
        ST_CB_BYTE_REQ:  if (sd_busy_i) state <= ST_CB_BYTE_WAIT;
        ST_CB_BYTE_WAIT: if (!sd_busy_i) begin
          if (block_byte_cnt == LAST_BYTE) begin
            state <= ST_CHECK_SIG;
          end else begin
            block_byte_cnt <= block_byte_cnt + 1'b1;
            state          <= ST_CB_BYTE_REQ;
          end
        end
        ST_CHECK_SIG: begin
          if (!sig_ok_i) begin
            halted_o <= 1'b1;
            state    <= ST_IDLE;
          end else if (!sd_busy_i) begin
            // feed data starts in the block after the control block
            block_addr     <= current_block + 32'd1;
            block_byte_cnt <= '0;
            fed_bytes      <= '0;
            state          <= ST_FEED_OPEN;
          end
        end
        ST_FEED_OPEN:      if (sd_busy_i) state <= ST_FEED_OPEN_WAIT;
        ST_FEED_OPEN_WAIT: if (!sd_busy_i) state <= ST_FEED_NEXT;
        ST_FEED_NEXT: begin
          if (word_full_i)    state <= ST_FEED_PULSE;
          else if (feed_done) state <= ST_STOP_FEED;
          else                state <= ST_FEED_BYTE_REQ;
        end
        ST_FEED_BYTE_REQ: if (sd_busy_i) state <= ST_FEED_BYTE_WAIT;
        ST_FEED_BYTE_WAIT: if (!sd_busy_i) begin
          fed_bytes <= fed_bytes + 64'd1;
          // track the block the multi-block read is in
          if (block_byte_cnt == LAST_BYTE) begin
            block_byte_cnt <= '0;
            block_addr     <= block_addr + 32'd1;
          end else begin
            block_byte_cnt <= block_byte_cnt + 1'b1;
          end
          state <= ST_FEED_NEXT;
        end
        ST_FEED_PULSE:    if (!uut_busy_i) state <= ST_UUT_BUSY_RISE;
        ST_UUT_BUSY_RISE: if (uut_busy_i) state <= ST_UUT_BUSY_FALL;
        ST_UUT_BUSY_FALL: if (!uut_busy_i) state <= ST_FEED_NEXT;
        ST_STOP_FEED: begin
          exec_cnt <= '0;
          state    <= ST_EXEC_WAIT;
        end
        ST_EXEC_WAIT: begin
          if (exec_over) state <= ST_COMPARE;
          else           exec_cnt <= exec_cnt + 32'd1;
        end
        ST_COMPARE: state <= ST_NEXT;
        ST_NEXT: begin
          current_block <= cb_i.next_block;
          state         <= ST_CB_SETUP;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // SD requests and UUT strobes
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    sd_cmd_o          = '0;
    uut_ctrl_o        = '0;
    ctrl_byte_valid_o = 1'b0;
    feed_byte_valid_o = 1'b0;
    block_clear_o     = 1'b0;
    result_capture_o  = 1'b0;
    compare_o         = 1'b0;
    case (state)
      ST_SD_RESET: begin
        sd_cmd_o.rst   = 1'b1;
        uut_ctrl_o.rst = 1'b1;
      end
      ST_SD_RESET_WAIT, ST_CHECK_SIG, ST_NEXT: uut_ctrl_o.rst = 1'b1;
      ST_CB_SETUP: begin
        uut_ctrl_o.rst = 1'b1;
        block_clear_o  = !sd_busy_i;
      end
      ST_CB_REQ, ST_CB_OPEN_WAIT: begin
        uut_ctrl_o.rst      = 1'b1;
        sd_cmd_o.read_block = 1'b1;
      end
      ST_CB_BYTE_REQ: begin
        uut_ctrl_o.rst      = 1'b1;
        sd_cmd_o.read_block = 1'b1;
        sd_cmd_o.read_byte  = 1'b1;
      end
      ST_CB_BYTE_WAIT: begin
        uut_ctrl_o.rst      = 1'b1;
        sd_cmd_o.read_block = 1'b1;
        ctrl_byte_valid_o   = !sd_busy_i;
      end
      ST_FEED_OPEN, ST_FEED_OPEN_WAIT, ST_FEED_NEXT,
      ST_UUT_BUSY_RISE, ST_UUT_BUSY_FALL: sd_cmd_o.read_multi = 1'b1;
      ST_FEED_BYTE_REQ: begin
        sd_cmd_o.read_multi = 1'b1;
        sd_cmd_o.read_byte  = 1'b1;
      end
      ST_FEED_BYTE_WAIT: begin
        sd_cmd_o.read_multi = 1'b1;
        feed_byte_valid_o   = !sd_busy_i;
      end
      ST_FEED_PULSE: begin
        sd_cmd_o.read_multi = 1'b1;
        uut_ctrl_o.feed     = !uut_busy_i;
      end
      ST_STOP_FEED: uut_ctrl_o.stop_feed = 1'b1;
      ST_EXEC_WAIT: result_capture_o = exec_over;
      ST_COMPARE:   compare_o = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== common/test_format_pkg.sv ====
/*
 * Test format definitions
 * control block layout on the card, UUT control and status
 * bundles and the sequencer states
 */
package test_format_pkg;

  localparam logic [31:0] SIGNATURE = 32'hAABB_CCDD;

  ////////////////////////////////////////////////////////////////////
  // field sizes in bytes, offsets follow from them
  ////////////////////////////////////////////////////////////////////
  localparam int SIG_BYTES       = 4;
  localparam int INPUT_BYTES     = 8;
  localparam int NEXT_BYTES      = 4;
  localparam int TOTAL_BYTES_LEN = 8;
  localparam int EXPECT_BYTES    = 4;
  localparam int FEED_BYTES      = 4;

  localparam int SIG_OFFSET    = 0;
  localparam int INPUT_OFFSET  = SIG_OFFSET + SIG_BYTES;
  localparam int NEXT_OFFSET   = INPUT_OFFSET + INPUT_BYTES;
  localparam int TOTAL_OFFSET  = NEXT_OFFSET + NEXT_BYTES;
  localparam int EXPECT_OFFSET = TOTAL_OFFSET + TOTAL_BYTES_LEN;
  localparam int CB_BYTES      = EXPECT_OFFSET + EXPECT_BYTES;

  localparam int CB_CNT_W   = $clog2(CB_BYTES + 1);
  localparam int FEED_CNT_W = $clog2(FEED_BYTES + 1);
  localparam int RESULT_W   = 8 * EXPECT_BYTES;

  // cycles allowed for a UUT run after stop-feed
  localparam logic [31:0] EXEC_TIMEOUT = 32'd4096;

  typedef struct packed {
    logic [8*SIG_BYTES-1:0]       signature;
    logic [8*INPUT_BYTES-1:0]     test_input;
    logic [8*NEXT_BYTES-1:0]      next_block;
    logic [8*TOTAL_BYTES_LEN-1:0] total_bytes;
    logic [8*EXPECT_BYTES-1:0]    expected;
  } control_block_t;

  typedef struct packed {
    logic rst;
    logic feed;
    logic stop_feed;
  } uut_ctrl_t;

  typedef struct packed {
    logic busy;
    logic done;
    logic error;
  } uut_status_t;

  typedef enum logic [4:0] {
    ST_IDLE, ST_SD_RESET, ST_SD_RESET_WAIT, ST_CB_SETUP, ST_CB_REQ,
    ST_CB_OPEN_WAIT, ST_CB_BYTE_REQ, ST_CB_BYTE_WAIT, ST_CHECK_SIG,
    ST_FEED_OPEN, ST_FEED_OPEN_WAIT, ST_FEED_NEXT, ST_FEED_BYTE_REQ,
    ST_FEED_BYTE_WAIT, ST_FEED_PULSE, ST_UUT_BUSY_RISE, ST_UUT_BUSY_FALL,
    ST_STOP_FEED, ST_EXEC_WAIT, ST_COMPARE, ST_NEXT
  } seq_state_e;

endpackage

// ==== common/sd_host_pkg.sv ====
/*
 * SD host definitions
 * request and response bundles of the byte-wide SD host,
 * block geometry and the first control block
 */
package sd_host_pkg;

  // bytes per SD block
  localparam int BLOCK_BYTES = 512;

  // byte index inside one block
  localparam int BYTE_CNT_W = $clog2(BLOCK_BYTES);

  // control block read first after start
  localparam logic [31:0] START_BLOCK = 32'h0010_0000;

  // level requests, each held until busy rises
  typedef struct packed {
    logic rst;
    logic read_block;
    logic read_multi;
    logic read_byte;
  } sd_cmd_t;

  // read data is valid when busy falls after a byte request
  typedef struct packed {
    logic       busy;
    logic [7:0] data;
  } sd_rsp_t;

endpackage
